//--- logic/ref_mem_pkg.sv
`default_nettype none

package ref_mem_pkg;

	// buffer geometry
	localparam int NUM_BANKS = 32;
	localparam int BANK_GROUP = 4;
	localparam int LINES_PER_BANK = 96;

	// first search point
	localparam int PRIME_LINES = 4;

	// coarse sweep over the down-sampled sub-area
	localparam int ROWS_PER_HALF = 24;
	localparam int HALF_OFFSET = 24;
	localparam int REUSE_FIRST = 7;
	localparam int REUSE_LAST = 19;
	localparam int SPLIT_STEP = 8;
	localparam int COLS_PER_BAND = 4;

	typedef logic [6:0] line_t;

	typedef logic [NUM_BANKS-1:0] bank_mask_t;

	// one line address per bank, bank 0 in the low field
	typedef line_t [NUM_BANKS-1:0] bank_addr_vec_t;

	// banks below the split read the far row
	typedef logic [4:0] split_t;

	typedef enum logic [1:0] {
		IDLE,
		PRELOAD,
		SWEEP
	} phase_t;

endpackage

`default_nettype wire

//--- logic/bank_rd_if.sv
`default_nettype none

interface bank_rd_if;
	import ref_mem_pkg::*;

	logic valid;
	line_t near_line;
	line_t far_line;
	split_t split;

	modport src (
		output valid,
		output near_line,
		output far_line,
		output split
	);

	modport dst (
		input valid,
		input near_line,
		input far_line,
		input split
	);

endinterface

`default_nettype wire

//--- logic/phase_sequencer.sv
`default_nettype none

module phase_sequencer (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic preload_last,
	input logic sweep_last,
	output logic preload_go,
	output logic sweep_go,
	output logic busy,
	output logic done
);
	import ref_mem_pkg::*;

	phase_t state;
	phase_t state_nxt;
	logic last_q;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: if (start) state_nxt = PRELOAD;
			PRELOAD: if (preload_last) state_nxt = SWEEP;
			SWEEP: if (sweep_last) state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			preload_go <= 1'b0;
			sweep_go <= 1'b0;
			busy <= 1'b0;
			last_q <= 1'b0;
			done <= 1'b0;
		end else begin
			state <= state_nxt;
			// write port starts one cycle into PRELOAD
			preload_go <= (state == PRELOAD) && !preload_last;
			// reads follow the last write with no gap
			sweep_go <= (state_nxt == SWEEP);
			busy <= (state != IDLE);
			// done lines up with the cycle after the last registered read
			last_q <= (state == SWEEP) && sweep_last;
			done <= last_q;
		end
	end

endmodule

`default_nettype wire

//--- logic/preload_writer.sv
`default_nettype none

module preload_writer #(
	parameter int LINES_PER_BANK = ref_mem_pkg::LINES_PER_BANK
) (
	input logic clk,
	input logic rst_n,
	input logic preload_go,
	output ref_mem_pkg::bank_mask_t bank_sel,
	output ref_mem_pkg::bank_addr_vec_t wr_addr,
	output logic preload_last
);
	import ref_mem_pkg::*;

	localparam int NUM_GROUPS = NUM_BANKS / BANK_GROUP;

	line_t line_cnt;
	logic [$clog2(NUM_GROUPS)-1:0] grp_cnt;
	logic line_wrap;

	assign line_wrap = (line_cnt == line_t'(LINES_PER_BANK - 1));

	// final line of the final group
	assign preload_last = preload_go && line_wrap && (grp_cnt == NUM_GROUPS - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bank_sel <= '0;
			line_cnt <= '0;
			grp_cnt <= '0;
		end else if (!preload_go) begin
			bank_sel <= '0;
			line_cnt <= '0;
			grp_cnt <= '0;
		end else begin
			// four adjacent banks per group
			bank_sel <= bank_mask_t'({BANK_GROUP{1'b1}}) << (BANK_GROUP * grp_cnt);
			if (line_wrap) begin
				line_cnt <= '0;
				grp_cnt <= grp_cnt + 1'b1;
			end else begin
				line_cnt <= line_cnt + 1'b1;
			end
		end
	end

	// same line to every bank, bank_sel picks the ones written
	always_ff @(posedge clk) begin
		if (preload_go) begin
			wr_addr <= {NUM_BANKS{line_cnt}};
		end
	end

endmodule

`default_nettype wire

//--- logic/ref_read_scheduler.sv
`default_nettype none

module ref_read_scheduler #(
	parameter int SEARCH_COLUMNS = 7
) (
	input logic clk,
	input logic rst_n,
	input logic sweep_go,
	bank_rd_if.src rd,
	output logic sweep_last
);
	import ref_mem_pkg::*;

	logic priming;
	logic [1:0] prime_cnt;
	logic [2:0] col;
	logic half;
	logic [4:0] row;
	logic stall;
	logic in_window;
	logic row_done;
	logic half_done;
	line_t base;
	line_t row_line;

	// rows shared by both block pairs are read twice
	assign in_window = (row >= REUSE_FIRST) && (row <= REUSE_LAST);

	// inside the window the row moves on its second read
	assign row_done = !in_window || stall;
	assign half_done = row_done && (row == ROWS_PER_HALF - 1);

	assign sweep_last = sweep_go && !priming && half_done && half
		&& (col == SEARCH_COLUMNS - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			priming <= 1'b1;
			prime_cnt <= '0;
			col <= '0;
			half <= 1'b0;
			row <= '0;
			stall <= 1'b0;
		end else if (!sweep_go || sweep_last) begin
			priming <= 1'b1;
			prime_cnt <= '0;
			col <= '0;
			half <= 1'b0;
			row <= '0;
			stall <= 1'b0;
		end else if (priming) begin
			prime_cnt <= prime_cnt + 2'd1;
			if (prime_cnt == PRIME_LINES - 1) begin
				priming <= 1'b0;
			end
		end else begin
			stall <= in_window && !stall;
			if (half_done) begin
				row <= '0;
				half <= !half;
				if (half) begin
					col <= col + 3'd1;
				end
			end else if (row_done) begin
				row <= row + 5'd1;
			end
		end
	end

	// base moves down one band every four columns, and again for the second half
	assign base = line_t'(HALF_OFFSET * (col / COLS_PER_BAND) + HALF_OFFSET * half);
	assign row_line = line_t'(row);

	always_comb begin
		rd.valid = sweep_go;
		if (priming) begin
			rd.near_line = line_t'(prime_cnt);
			rd.far_line = line_t'(prime_cnt);
			rd.split = '0;
		end else begin
			rd.near_line = base + row_line;
			rd.far_line = base + line_t'(HALF_OFFSET) + row_line;
			// split walks 8 banks per column inside a band
			rd.split = split_t'(SPLIT_STEP * (col % COLS_PER_BAND));
		end
	end

endmodule

`default_nettype wire

//--- logic/bank_addr_fanout.sv
`default_nettype none

module bank_addr_fanout (
	input logic clk,
	input logic rst_n,
	bank_rd_if.dst rd,
	output ref_mem_pkg::bank_addr_vec_t rd_addr,
	output logic rd_en,
	output ref_mem_pkg::split_t shift_value
);
	import ref_mem_pkg::*;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_en <= 1'b0;
		end else begin
			rd_en <= rd.valid;
		end
	end

	// addresses hold between requests
	always_ff @(posedge clk) begin
		if (rd.valid) begin
			for (int i = 0; i < NUM_BANKS; i++) begin
				// low banks take the far row
				if (i < int'(rd.split)) begin
					rd_addr[i] <= rd.far_line;
				end else begin
					rd_addr[i] <= rd.near_line;
				end
			end
			shift_value <= rd.split;
		end
	end

endmodule

`default_nettype wire

//--- logic/ref_mem_ctrl_top.sv
`default_nettype none

module ref_mem_ctrl_top #(
	parameter int SEARCH_COLUMNS = 7,
	parameter int LINES_PER_BANK = ref_mem_pkg::LINES_PER_BANK
) (
	input logic clk,
	input logic rst_n,
	input logic start,
	output ref_mem_pkg::bank_mask_t bank_sel,
	output ref_mem_pkg::bank_addr_vec_t wr_addr,
	output ref_mem_pkg::bank_addr_vec_t rd_addr,
	output logic rd_en,
	output ref_mem_pkg::split_t shift_value,
	output logic busy,
	output logic done
);

	logic preload_go;
	logic preload_last;
	logic sweep_go;
	logic sweep_last;

	// scheduler to fan-out
	bank_rd_if rd_req ();

	phase_sequencer u_seq (
		.clk (clk),
		.rst_n (rst_n),
		.start (start),
		.preload_last (preload_last),
		.sweep_last (sweep_last),
		.preload_go (preload_go),
		.sweep_go (sweep_go),
		.busy (busy),
		.done (done)
	);

	preload_writer #(
		.LINES_PER_BANK (LINES_PER_BANK)
	) u_writer (
		.clk (clk),
		.rst_n (rst_n),
		.preload_go (preload_go),
		.bank_sel (bank_sel),
		.wr_addr (wr_addr),
		.preload_last (preload_last)
	);

	ref_read_scheduler #(
		.SEARCH_COLUMNS (SEARCH_COLUMNS)
	) u_sched (
		.clk (clk),
		.rst_n (rst_n),
		.sweep_go (sweep_go),
		.rd (rd_req.src),
		.sweep_last (sweep_last)
	);

	bank_addr_fanout u_fanout (
		.clk (clk),
		.rst_n (rst_n),
		.rd (rd_req.dst),
		.rd_addr (rd_addr),
		.rd_en (rd_en),
		.shift_value (shift_value)
	);

endmodule

`default_nettype wire

//--- sim/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	if (s[0]) begin
		return (s >> 1) ^ 32'h8020_0003;
	end
	return s >> 1;
endfunction

// write n of the preload, group by group
function automatic void exp_write(input int n, output bank_mask_t sel,
		output bank_addr_vec_t addr);
	int grp;
	int wr_line;
	grp = n / LINES_PER_BANK;
	wr_line = n % LINES_PER_BANK;
	sel = '0;
	for (int b = 0; b < BANK_GROUP; b++) begin
		sel[BANK_GROUP * grp + b] = 1'b1;
	end
	for (int i = 0; i < NUM_BANKS; i++) begin
		addr[i] = line_t'(wr_line);
	end
endfunction

// read m, prime first and then the coarse sweep
function automatic void exp_read(input int m, output bank_addr_vec_t addr,
		output split_t split);
	int per_half;
	int idx;
	int col;
	int half;
	int q;
	int row;
	int reps;
	int base;
	int near_l;
	int far_l;
	int sp;
	if (m < PRIME_LINES) begin
		near_l = m;
		far_l = m;
		sp = 0;
	end else begin
		per_half = ROWS_PER_HALF + (REUSE_LAST - REUSE_FIRST + 1);
		idx = m - PRIME_LINES;
		col = idx / (2 * per_half);
		half = (idx / per_half) % 2;
		q = idx % per_half;
		row = -1;
		// window rows take two requests each
		for (int r = 0; r < ROWS_PER_HALF; r++) begin
			reps = (r >= REUSE_FIRST && r <= REUSE_LAST) ? 2 : 1;
			if (row < 0) begin
				if (q < reps) begin
					row = r;
				end else begin
					q = q - reps;
				end
			end
		end
		base = HALF_OFFSET * (col / COLS_PER_BAND) + HALF_OFFSET * half;
		near_l = base + row;
		far_l = base + HALF_OFFSET + row;
		sp = SPLIT_STEP * (col % COLS_PER_BAND);
	end
	for (int i = 0; i < NUM_BANKS; i++) begin
		addr[i] = (i < sp) ? line_t'(far_l) : line_t'(near_l);
	end
	split = split_t'(sp);
endfunction

`endif

//--- sim/tb_ref_mem_ctrl.sv
`default_nettype none

module tb_ref_mem_ctrl;
	timeunit 1ns;
	timeprecision 100ps;
	import ref_mem_pkg::*;

	`include "tb_ref_model.svh"

	localparam int SEARCH_COLUMNS = 7;
	localparam int TOTAL_WRITES = NUM_BANKS / BANK_GROUP * LINES_PER_BANK;
	localparam int TOTAL_READS = PRIME_LINES
		+ SEARCH_COLUMNS * 2 * (ROWS_PER_HALF + REUSE_LAST - REUSE_FIRST + 1);

	logic clk;
	logic rst_n;
	logic start;
	bank_mask_t bank_sel;
	bank_addr_vec_t wr_addr;
	bank_addr_vec_t rd_addr;
	logic rd_en;
	split_t shift_value;
	logic busy;
	logic done;

	logic [31:0] lfsr_state;
	int cyc = 0;
	int start_edge = -100;
	int run_id = 0;
	int seen_run = 0;
	int n_wr = 0;
	int n_rd = 0;
	int n_done = 0;
	int last_wr_cyc = 0;
	int last_rd_cyc = 0;

	ref_mem_ctrl_top #(
		.SEARCH_COLUMNS (SEARCH_COLUMNS),
		.LINES_PER_BANK (LINES_PER_BANK)
	) UUT (
		.clk (clk),
		.rst_n (rst_n),
		.start (start),
		.bank_sel (bank_sel),
		.wr_addr (wr_addr),
		.rd_addr (rd_addr),
		.rd_en (rd_en),
		.shift_value (shift_value),
		.busy (busy),
		.done (done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_mask(input string name, input bank_mask_t exp_v, input bank_mask_t act_v);
		if (act_v !== exp_v) begin
			fail_stop($sformatf("mismatch at %0t: %s expected %h, got %h",
				$time, name, exp_v, act_v));
		end
	endtask

	task automatic check_vec(input string name, input bank_addr_vec_t exp_v,
			input bank_addr_vec_t act_v);
		if (act_v !== exp_v) begin
			fail_stop($sformatf("mismatch at %0t: %s expected %h, got %h",
				$time, name, exp_v, act_v));
		end
	endtask

	task automatic check_split(input string name, input split_t exp_v, input split_t act_v);
		if (act_v !== exp_v) begin
			fail_stop($sformatf("mismatch at %0t: %s expected %0d, got %0d",
				$time, name, exp_v, act_v));
		end
	endtask

	task automatic check_bit(input string name, input logic exp_v, input logic act_v);
		if (act_v !== exp_v) begin
			fail_stop($sformatf("mismatch at %0t: %s expected %b, got %b",
				$time, name, exp_v, act_v));
		end
	endtask

	task automatic draw_bits(input int nbits, output int val);
		val = 0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = (val << 1) | int'(lfsr_state[0]);
		end
	endtask

	// outputs must stay quiet while idle
	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(negedge clk);
			check_mask("bank_sel", '0, bank_sel);
			check_bit("rd_en", 1'b0, rd_en);
			check_bit("busy", 1'b0, busy);
			check_bit("done", 1'b0, done);
		end
	endtask

	task automatic wait_for_done(input int limit);
		int k;
		k = 0;
		while (done !== 1'b1) begin
			@(negedge clk);
			k++;
			if (k > limit) begin
				fail_stop("timeout while waiting for done");
			end
		end
	endtask

	// start is stable at the rising edge
	always @(posedge clk) begin
		cyc = cyc + 1;
		if (rst_n && start) begin
			start_edge = cyc;
			run_id = run_id + 1;
		end
	end

	always @(negedge clk) begin : compare_outputs
		bank_mask_t e_sel;
		bank_addr_vec_t e_addr;
		split_t e_split;
		if (rst_n) begin
			if (seen_run != run_id) begin
				seen_run = run_id;
				n_wr = 0;
				n_rd = 0;
				n_done = 0;
			end
			if (bank_sel != '0) begin
				if (n_wr == 0 && cyc != start_edge + 2) begin
					fail_stop("first write is not two cycles after start");
				end
				if (n_wr != 0 && cyc != last_wr_cyc + 1) begin
					fail_stop("gap between preload writes");
				end
				if (n_wr >= TOTAL_WRITES) begin
					fail_stop("more preload writes than expected");
				end
				exp_write(n_wr, e_sel, e_addr);
				check_mask("bank_sel", e_sel, bank_sel);
				check_vec("wr_addr", e_addr, wr_addr);
				check_bit("busy", 1'b1, busy);
				last_wr_cyc = cyc;
				n_wr++;
			end
			if (rd_en) begin
				if (n_rd == 0 && (n_wr != TOTAL_WRITES || cyc != last_wr_cyc + 1)) begin
					fail_stop("first read does not follow the last write");
				end
				if (n_rd != 0 && cyc != last_rd_cyc + 1) begin
					fail_stop("rd_en dropped before the sweep ended");
				end
				if (n_rd >= TOTAL_READS) begin
					fail_stop("more reads than expected");
				end
				exp_read(n_rd, e_addr, e_split);
				check_vec("rd_addr", e_addr, rd_addr);
				check_split("shift_value", e_split, shift_value);
				check_mask("bank_sel", '0, bank_sel);
				check_bit("busy", 1'b1, busy);
				last_rd_cyc = cyc;
				n_rd++;
			end
			if (done) begin
				if (n_done != 0) begin
					fail_stop("done pulsed more than once");
				end
				if (n_rd != TOTAL_READS || cyc != last_rd_cyc + 1) begin
					fail_stop("done is not one cycle after the last read");
				end
				check_bit("busy", 1'b0, busy);
				check_bit("rd_en", 1'b0, rd_en);
				n_done++;
			end
		end
	end

	initial begin : stimulus
		int gap;
		start = 1'b0;
		rst_n = 1'b0;
		lfsr_state = 32'hf09395f5;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int run = 0; run < 2; run++) begin
			draw_bits(5, gap);
			idle_cycles(gap + 3);
			@(negedge clk);
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
			wait_for_done(TOTAL_WRITES + TOTAL_READS + 20);
		end
		idle_cycles(4);
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+sim
logic/ref_mem_pkg.sv
logic/bank_rd_if.sv
logic/phase_sequencer.sv
logic/preload_writer.sv
logic/ref_read_scheduler.sv
logic/bank_addr_fanout.sv
logic/ref_mem_ctrl_top.sv
sim/tb_ref_mem_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing -j 0
TOP = tb_ref_mem_ctrl
FLIST = flist.f
OBJ_DIR = obj_dir
PASS_MSG = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# status comes from the grep, so a missing pass line fails the target
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
